// ==== hw/core_state_pkg.sv ====
`default_nettype none

package core_state_pkg;

  // sequencer states, one REQ/WAIT pair per memory access
  typedef enum logic [3:0] {
    S_IDLE       = 4'd0,
    S_FETCH_REQ  = 4'd1,
    S_FETCH_WAIT = 4'd2,
    S_SRC0_REQ   = 4'd3,
    S_SRC0_WAIT  = 4'd4,
    S_SRC1_REQ   = 4'd5,
    S_SRC1_WAIT  = 4'd6,
    S_EXEC       = 4'd7,
    S_WR_LO_REQ  = 4'd8,
    S_WR_LO_WAIT = 4'd9,
    // high word, MUL only
    S_WR_HI_REQ  = 4'd10,
    S_WR_HI_WAIT = 4'd11,
    S_HALT       = 4'd12
  } core_state_t;

endpackage

`default_nettype wire

// ==== hw/core_cmd_pkg.sv ====
`default_nettype none

package core_cmd_pkg;

  // unlisted codes are treated as halt
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MUL  = 4'd5,
    OP_JZ   = 4'd6,
    OP_HALT = 4'd7
  } opcode_t;

  // command word layout, bits 27..24 unused
  localparam int OPC_MSB  = 31;
  localparam int OPC_LSB  = 28;
  localparam int DST_MSB  = 23;
  localparam int DST_LSB  = 16;
  localparam int SRC1_MSB = 15;
  localparam int SRC1_LSB = 8;
  localparam int SRC0_MSB = 7;
  localparam int SRC0_LSB = 0;

  // every offset field is 8 bits wide
  localparam int OFF_W = 8;

endpackage

`default_nettype wire

// ==== hw/core_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_sequencer
  import core_state_pkg::*;
  import core_cmd_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  opcode_t     opcode,
  input  logic        zero,
  input  logic        read_dn,
  input  logic        write_dn,
  output core_state_t state,
  output logic        busy,
  output logic        halted
);

  core_state_t next_state;

  // command word is decoded straight from the data bus
  if (DATA_W != 32) begin : g_bad_data_w
    $error("core_sequencer: command decode needs DATA_W of 32");
  end

  // offsets are 8 bits and must fit the address
  if (ADDR_W < 8) begin : g_bad_addr_w
    $error("core_sequencer: ADDR_W must be at least 8");
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE, S_HALT: begin
        if (start) begin
          next_state = S_FETCH_REQ;
        end
      end
      S_FETCH_REQ: next_state = S_FETCH_WAIT;
      S_FETCH_WAIT: begin
        if (read_dn) begin
          case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_JZ: begin
              next_state = S_SRC0_REQ;
            end
            default: next_state = S_HALT;
          endcase
        end
      end
      S_SRC0_REQ: next_state = S_SRC0_WAIT;
      S_SRC0_WAIT: begin
        // jz has a single operand
        if (read_dn) begin
          next_state = (opcode == OP_JZ) ? S_EXEC : S_SRC1_REQ;
        end
      end
      S_SRC1_REQ: next_state = S_SRC1_WAIT;
      S_SRC1_WAIT: begin
        if (read_dn) begin
          next_state = S_EXEC;
        end
      end
      S_EXEC: begin
        if (opcode == OP_JZ) begin
          // taken or not, the pointer moves this cycle and we refetch
          next_state = S_FETCH_REQ;
        end else begin
          next_state = S_WR_LO_REQ;
        end
      end
      S_WR_LO_REQ: next_state = S_WR_LO_WAIT;
      S_WR_LO_WAIT: begin
        if (write_dn) begin
          next_state = (opcode == OP_MUL) ? S_WR_HI_REQ : S_FETCH_REQ;
        end
      end
      S_WR_HI_REQ: next_state = S_WR_HI_WAIT;
      S_WR_HI_WAIT: begin
        if (write_dn) begin
          next_state = S_FETCH_REQ;
        end
      end
      default: next_state = S_IDLE;
    endcase
  end

  assign busy   = (state != S_IDLE) && (state != S_HALT);
  assign halted = (state == S_HALT);

endmodule

`default_nettype wire

// ==== hw/mem_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_manager
  import core_state_pkg::*;
  import core_cmd_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  core_state_t       state,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic [DATA_W-1:0] rdata,
  input  logic              read_dn,
  input  logic              zero,
  input  logic [DATA_W-1:0] res_lo,
  input  logic [DATA_W-1:0] res_hi,
  output opcode_t           opcode,
  output logic [DATA_W-1:0] src0_val,
  output logic [DATA_W-1:0] src1_val,
  output logic [ADDR_W-1:0] addr,
  output logic [DATA_W-1:0] wdata,
  output logic              read_q,
  output logic              write_q
);

  logic [ADDR_W-1:0] cmd_ptr;
  logic [DATA_W-1:0] cmd_reg;
  logic [DATA_W-1:0] cmd_word;
  logic [OFF_W-1:0]  dst_off;
  logic [OFF_W-1:0]  src1_off;
  logic [OFF_W-1:0]  src0_off;
  logic [ADDR_W-1:0] offset;

  // sequencer needs the opcode in the same cycle as read_dn
  assign cmd_word = (state == S_FETCH_WAIT) ? rdata : cmd_reg;
  assign opcode   = opcode_t'(cmd_word[OPC_MSB:OPC_LSB]);

  assign dst_off  = cmd_reg[DST_MSB:DST_LSB];
  assign src1_off = cmd_reg[SRC1_MSB:SRC1_LSB];
  assign src0_off = cmd_reg[SRC0_MSB:SRC0_LSB];

  // command and operand capture
  always_ff @(posedge clk) begin
    if (read_dn) begin
      case (state)
        S_FETCH_WAIT: cmd_reg  <= rdata;
        S_SRC0_WAIT:  src0_val <= rdata;
        S_SRC1_WAIT:  src1_val <= rdata;
        default: ;
      endcase
    end
  end

  // command pointer, cleared while stopped so start begins at offset 0
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ptr <= '0;
    end else if (state == S_IDLE || state == S_HALT) begin
      cmd_ptr <= '0;
    end else if (state == S_EXEC) begin
      if (opcode == OP_JZ && zero) begin
        cmd_ptr <= ADDR_W'(dst_off);
      end else begin
        cmd_ptr <= cmd_ptr + ADDR_W'(1);
      end
    end
  end

  // offset stays put through each wait state, so addr holds until done
  always_comb begin
    case (state)
      S_SRC0_REQ, S_SRC0_WAIT:   offset = ADDR_W'(src0_off);
      S_SRC1_REQ, S_SRC1_WAIT:   offset = ADDR_W'(src1_off);
      S_WR_LO_REQ, S_WR_LO_WAIT: offset = ADDR_W'(dst_off);
      S_WR_HI_REQ, S_WR_HI_WAIT: offset = ADDR_W'(dst_off) + ADDR_W'(1);
      default:                   offset = cmd_ptr;
    endcase
  end

  assign addr = base_addr + offset;

  // high word only in the mul tail
  assign wdata = (state == S_WR_HI_REQ || state == S_WR_HI_WAIT) ? res_hi : res_lo;

  assign read_q  = (state == S_FETCH_REQ) || (state == S_SRC0_REQ) || (state == S_SRC1_REQ);
  assign write_q = (state == S_WR_LO_REQ) || (state == S_WR_HI_REQ);

endmodule

`default_nettype wire

// ==== hw/core_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_alu
  import core_state_pkg::*;
  import core_cmd_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  core_state_t       state,
  input  opcode_t           opcode,
  input  logic [DATA_W-1:0] src0_val,
  input  logic [DATA_W-1:0] src1_val,
  output logic [DATA_W-1:0] res_lo,
  output logic [DATA_W-1:0] res_hi,
  output logic              zero
);

  logic [2*DATA_W-1:0] product;

  // full width unsigned product
  assign product = {{DATA_W{1'b0}}, src0_val} * {{DATA_W{1'b0}}, src1_val};

  // jz test on the first operand
  assign zero = (src0_val == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_lo <= '0;
      res_hi <= '0;
    end else if (state == S_EXEC) begin
      case (opcode)
        OP_ADD: res_lo <= src0_val + src1_val;
        // src0 - src1
        OP_SUB: res_lo <= src0_val - src1_val;
        OP_AND: res_lo <= src0_val & src1_val;
        OP_OR:  res_lo <= src0_val | src1_val;
        OP_XOR: res_lo <= src0_val ^ src1_val;
        OP_MUL: begin
          res_lo <= product[DATA_W-1:0];
          res_hi <= product[2*DATA_W-1:DATA_W];
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/internal_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module internal_bus
  import core_state_pkg::*;
  import core_cmd_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic              read_dn,
  input  logic [DATA_W-1:0] rdata,
  input  logic              write_dn,
  output logic [ADDR_W-1:0] addr,
  output logic [DATA_W-1:0] wdata,
  output logic              read_q,
  output logic              write_q,
  output logic              busy,
  output logic              halted
);

  core_state_t       state;
  opcode_t           opcode;
  logic              zero;
  logic [DATA_W-1:0] res_lo;
  logic [DATA_W-1:0] res_hi;
  logic [DATA_W-1:0] src0_val;
  logic [DATA_W-1:0] src1_val;

  core_sequencer #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_seq (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .opcode  (opcode),
    .zero    (zero),
    .read_dn (read_dn),
    .write_dn(write_dn),
    .state   (state),
    .busy    (busy),
    .halted  (halted)
  );

  // owns the memory port
  mem_manager #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .base_addr(base_addr),
    .rdata    (rdata),
    .read_dn  (read_dn),
    .zero     (zero),
    .res_lo   (res_lo),
    .res_hi   (res_hi),
    .opcode   (opcode),
    .src0_val (src0_val),
    .src1_val (src1_val),
    .addr     (addr),
    .wdata    (wdata),
    .read_q   (read_q),
    .write_q  (write_q)
  );

  core_alu #(
    .DATA_W(DATA_W)
  ) u_alu (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .opcode  (opcode),
    .src0_val(src0_val),
    .src1_val(src1_val),
    .res_lo  (res_lo),
    .res_hi  (res_hi),
    .zero    (zero)
  );

endmodule

`default_nettype wire

// ==== tb/internal_bus_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module internal_bus_asserts #(
  parameter int ADDR_W = 16
) (
  input logic              clk,
  input logic              rst,
  input logic              read_q,
  input logic              write_q,
  input logic              read_dn,
  input logic              write_dn,
  input logic [ADDR_W-1:0] addr,
  input logic              busy,
  input logic              halted
);

  logic              pending;
  logic [ADDR_W-1:0] held_addr;
  logic              err_excl = 1'b0;
  logic              err_rd_pulse = 1'b0;
  logic              err_wr_pulse = 1'b0;
  logic              err_addr = 1'b0;
  logic              err_halt = 1'b0;
  logic              failed;

  // address seen at the strobe, held until done
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (read_q || write_q) begin
      pending   <= 1'b1;
      held_addr <= addr;
    end else if (read_dn || write_dn) begin
      pending <= 1'b0;
    end
  end

  assign failed = err_excl | err_rd_pulse | err_wr_pulse | err_addr | err_halt;

  a_excl: assert property (@(posedge clk) disable iff (rst) !(read_q && write_q))
    else begin
      err_excl = 1'b1;
      $error("read_q and write_q high in the same cycle");
    end

  a_rd_pulse: assert property (@(posedge clk) disable iff (rst) read_q |=> !read_q)
    else begin
      err_rd_pulse = 1'b1;
      $error("read_q held longer than one cycle");
    end

  a_wr_pulse: assert property (@(posedge clk) disable iff (rst) write_q |=> !write_q)
    else begin
      err_wr_pulse = 1'b1;
      $error("write_q held longer than one cycle");
    end

  a_addr_hold: assert property (@(posedge clk) disable iff (rst) pending |-> addr == held_addr)
    else begin
      err_addr = 1'b1;
      $error("addr changed between strobe and done");
    end

  a_halt: assert property (@(posedge clk) disable iff (rst) halted |-> !busy)
    else begin
      err_halt = 1'b1;
      $error("busy high while halted");
    end

endmodule

`default_nettype wire

// ==== tb/tb_internal_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_internal_bus;

  localparam int    ADDR_W       = 16;
  localparam int    DATA_W       = 32;
  localparam int    MEM_WORDS    = 1 << ADDR_W;
  localparam string PATTERN_FILE = "tb/internal_bus_patterns.txt";

  logic              clk;
  logic              rst;
  logic              start;
  logic [ADDR_W-1:0] base_addr;
  logic              read_dn;
  logic [DATA_W-1:0] rdata;
  logic              write_dn;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              read_q;
  logic              write_q;
  logic              busy;
  logic              halted;
  logic              assert_failed;

  logic [DATA_W-1:0] mem [0:MEM_WORDS-1];
  logic [ADDR_W-1:0] exp_addr [$];
  logic [DATA_W-1:0] exp_data [$];
  logic [ADDR_W-1:0] base_val;
  int                exp_idx = 0;
  int                n_mem = 0;
  int                cycles = 0;
  int                cycle_limit = 1000;
  int unsigned       lcg_state = 44;

  // memory model request state
  logic              pending = 1'b0;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  int                wait_cnt;

  internal_bus #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_internal_bus (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .base_addr(base_addr),
    .read_dn  (read_dn),
    .rdata    (rdata),
    .write_dn (write_dn),
    .addr     (addr),
    .wdata    (wdata),
    .read_q   (read_q),
    .write_q  (write_q),
    .busy     (busy),
    .halted   (halted)
  );

  bind internal_bus internal_bus_asserts #(.ADDR_W(ADDR_W)) u_asserts (
    .clk     (clk),
    .rst     (rst),
    .read_q  (read_q),
    .write_q (write_q),
    .read_dn (read_dn),
    .write_dn(write_dn),
    .addr    (addr),
    .busy    (busy),
    .halted  (halted)
  );

  assign assert_failed = u_internal_bus.u_asserts.failed;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    assert (got === expected) else
      stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                              $time, name, expected, got));
  endtask

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // unloaded words carry their own address
  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          cnt;
    int          ch;
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen(PATTERN_FILE, "r");
    assert (fd != 0) else stop_on_error("cannot open the pattern file");
    while ($fscanf(fd, " %c", tag) == 1) begin
      if (tag == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if (tag == "B") begin
        cnt = $fscanf(fd, "%h", a);
        assert (cnt == 1) else stop_on_error("base line in pattern file is malformed");
        base_val = a[ADDR_W-1:0];
      end else if (tag == "M" || tag == "W") begin
        cnt = $fscanf(fd, "%h %h", a, d);
        assert (cnt == 2) else stop_on_error("memory or write line is malformed");
        if (tag == "M") begin
          mem[a[ADDR_W-1:0]] = d[DATA_W-1:0];
          n_mem++;
        end else begin
          exp_addr.push_back(a[ADDR_W-1:0]);
          exp_data.push_back(d[DATA_W-1:0]);
        end
      end else begin
        stop_on_error($sformatf("unknown tag '%c' in pattern file", tag));
      end
    end
    $fclose(fd);
  endtask

  // each write is matched against the next entry of the list
  task automatic check_write();
    assert (exp_idx < exp_addr.size()) else
      stop_on_error($sformatf("unexpected write of %h to %h after the write list ran out",
                              wdata, addr));
    compare_value("addr", 32'(addr), 32'(exp_addr[exp_idx]));
    compare_value("wdata", wdata, exp_data[exp_idx]);
    exp_idx++;
  endtask

  // memory model, answers every strobe after 1 to 4 cycles
  always @(posedge clk) begin
    read_dn  <= 1'b0;
    write_dn <= 1'b0;
    if (rst) begin
      pending = 1'b0;
    end else begin
      if (!pending && (read_q || write_q)) begin
        pending   = 1'b1;
        req_write = write_q;
        req_addr  = addr;
        wait_cnt  = int'(next_rand() % 4);
        if (write_q) begin
          check_write();
        end
      end
      if (pending) begin
        if (wait_cnt == 0) begin
          pending = 1'b0;
          if (req_write) begin
            write_dn <= 1'b1;
          end else begin
            rdata   <= mem[req_addr];
            read_dn <= 1'b1;
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      stop_on_error($sformatf("timeout, core did not halt within %0d cycles", cycle_limit));
    end
    if (assert_failed) begin
      stop_on_error("a bound assertion on the memory port failed");
    end
  end

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    base_addr = '0;
    read_dn   = 1'b0;
    rdata     = '0;
    write_dn  = 1'b0;
    fill_memory();
    load_patterns();
    cycle_limit = (exp_addr.size() + n_mem) * 20 + 100;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    compare_value("read_q", 32'(read_q), 32'd0);
    compare_value("write_q", 32'(write_q), 32'd0);
    compare_value("busy", 32'(busy), 32'd0);
    compare_value("halted", 32'(halted), 32'd0);

    base_addr <= base_val;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // first fetch comes straight from base_addr
    @(posedge clk);
    compare_value("read_q", 32'(read_q), 32'd1);
    compare_value("addr", 32'(addr), 32'(base_val));

    while (!halted) @(posedge clk);
    compare_value("busy", 32'(busy), 32'd0);
    assert (exp_idx == exp_addr.size()) else
      stop_on_error($sformatf("core halted after only %0d of %0d expected writes",
                              exp_idx, exp_addr.size()));
    repeat (8) begin
      @(posedge clk);
      assert (!read_q && !write_q) else stop_on_error("memory strobe raised after halt");
    end

    if (!assert_failed) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_on_error("a bound assertion on the memory port failed");
    end
  end

endmodule

`default_nettype wire

// ==== tb/internal_bus_patterns.txt ====
# M addr data  preloads a memory word, B base sets base_addr
# W addr data  is the next write the core must issue, in order
B 0100
# commands: add, sub, and, or, xor, mul, jz not taken, jz taken, two skipped, sub, halt
M 0100 00604140
M 0101 10614140
M 0102 20624342
M 0103 30634342
M 0104 40644342
M 0105 50654544
M 0106 60200040
M 0107 600A0046
M 0108 00704140
M 0109 00714140
M 010A 10674041
M 010B 70000000
# operands
M 0140 89ABCDEF
M 0141 12345678
M 0142 F0F0AA55
M 0143 3C3C0FF0
M 0144 FFFFFFFF
M 0145 00000003
M 0146 00000000
# expected writes, mul low word then high word
W 0160 9BE02467
W 0161 77777777
W 0162 30300A50
W 0163 FCFCAFF5
W 0164 CCCCA5A5
W 0165 FFFFFFFD
W 0166 00000002
W 0167 88888889

// ==== compile.f ====
hw/core_state_pkg.sv
hw/core_cmd_pkg.sv
hw/core_sequencer.sv
hw/mem_manager.sv
hw/core_alu.sv
hw/internal_bus.sv
tb/internal_bus_asserts.sv
tb/tb_internal_bus.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_internal_bus
FILELIST  := compile.f
SIM       := obj_dir/V$(TOP)
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
